// File: vlog.f
+incdir+design
design/stb_pkg.sv
design/period_if.sv
design/time_base.sv
design/edge_stamp.sv
design/period_meter.sv
design/strobe_scheduler.sv
design/stb_gen_top.sv
verification/tb_stb_gen.sv

// File: run.sh
#!/bin/sh
# build and run the stb_gen testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_stb_gen \
	-f vlog.f \
	-o tb_stb_gen

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/tb_stb_gen

// File: verification/tb_stb_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "stb_config.svh"

module tb_stb_gen;

	localparam int unsigned MAX_P         = `STB_MAX_PERIOD;
	localparam int unsigned RUN_PERIODS   = 10;
	// upper bound on periods spent in one test phase
	localparam int unsigned PHASE_PERIODS = 20;
	// input period below STB_MIN_PERIOD
	localparam int unsigned SHORT_H       = 2;
	localparam int unsigned SHORT_L       = 3;

	logic               clk_i = 1'b0;
	logic               arstn_i;
	logic               sig_i;
	logic               stb_req_i;
	logic               stb_o;
	logic               stb_valid_o;
	logic               rdy_o;
	logic               err_o;
	stb_pkg::stb_time_t stb_period_o;

	// input wave control, read by the generator on falling edges
	int unsigned hi_len     = 4;
	int unsigned lo_len     = 4;
	logic        wave_on    = 1'b0;
	int unsigned edges_sent = 0;
	int unsigned budget     = 0;

	// checker state
	logic               stb_prev    = 1'b0;
	logic               rdy_prev    = 1'b0;
	logic               req_prev    = 1'b0;
	logic               req_pending = 1'b0;
	logic               have_rise   = 1'b0;
	int unsigned        offset      = 0;
	int unsigned        req_count   = 0;
	int unsigned        pulse_count = 0;
	stb_pkg::stb_time_t cur_per     = '0;
	stb_pkg::stb_time_t per_old     = '0;
	stb_pkg::stb_time_t per_new     = '0;

	stb_gen_top i_stb_gen_top (
		.clk_i        (clk_i),
		.arstn_i      (arstn_i),
		.sig_i        (sig_i),
		.stb_req_i    (stb_req_i),
		.stb_o        (stb_o),
		.stb_valid_o  (stb_valid_o),
		.rdy_o        (rdy_o),
		.err_o        (err_o),
		.stb_period_o (stb_period_o)
	);

	always #20 clk_i = ~clk_i;

	// strobe level at a cycle offset from the last boundary
	function automatic logic expected_strobe(input stb_pkg::stb_time_t p,
		input int unsigned off);
		return stb_pkg::stb_time_t'(off) < p - stb_pkg::stb_time_t'(`STB_ZERO_HOLD);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_time(input string name, input stb_pkg::stb_time_t got,
		input stb_pkg::stb_time_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t %s: got %b, expected %b", $time, name, got, exp));
		end
	endtask

	// new expectations on a falling edge, new lengths on a rising edge
	task automatic set_wave(input int unsigned h, input int unsigned l, input logic good);
		@(negedge clk_i);
		if (good) begin
			per_old = per_new;
			per_new = stb_pkg::stb_time_t'(h + l);
		end
		@(posedge clk_i);
		hi_len = h;
		lo_len = l;
	endtask

	task automatic wait_flag(input logic on_err, input logic level,
		input int unsigned max_cycles, input string what);
		int unsigned waited;
		waited = 0;
		@(negedge clk_i);
		while ((on_err ? err_o : rdy_o) !== level) begin
			if (waited > max_cycles) abort_run(what);
			@(negedge clk_i);
			waited++;
		end
	endtask

	task automatic wait_period(input int unsigned p, input int unsigned max_cycles);
		int unsigned waited;
		waited = 0;
		@(negedge clk_i);
		while (stb_period_o !== stb_pkg::stb_time_t'(p)) begin
			if (waited > max_cycles) abort_run("stb_period_o never took the new input period");
			@(negedge clk_i);
			waited++;
		end
	endtask

	task automatic request_strobe(input int unsigned p);
		int unsigned seen;
		int unsigned waited;
		seen   = pulse_count;
		waited = 0;
		@(negedge clk_i);
		stb_req_i = 1'b1;
		repeat (3) @(negedge clk_i);
		stb_req_i = 1'b0;
		while (pulse_count == seen) begin
			if (waited > 3 * p + 10) abort_run("no stb_valid_o pulse after a strobe request");
			@(negedge clk_i);
			waited++;
		end
	endtask

	// ------------------------------
	// input wave generator, one whole period per pass
	initial begin
		int unsigned h;
		int unsigned l;
		sig_i = 1'b0;
		forever begin
			@(negedge clk_i);
			if (wave_on) begin
				h          = hi_len;
				l          = lo_len;
				sig_i      = 1'b1;
				edges_sent = edges_sent + 1;
				repeat (h) @(negedge clk_i);
				sig_i = 1'b0;
				repeat (l - 1) @(negedge clk_i);
			end
		end
	end

	// ------------------------------
	// output checker
	always @(posedge clk_i) begin
		if (arstn_i) begin
			// quiet until the third input edge
			if (edges_sent < 3) begin
				check_bit("stb_o", stb_o, 1'b0);
				check_bit("rdy_o", rdy_o, 1'b0);
				check_bit("stb_valid_o", stb_valid_o, 1'b0);
				check_bit("err_o", err_o, 1'b0);
				check_time("stb_period_o", stb_period_o, '0);
			end
			check_bit("rdy_o and err_o", rdy_o & err_o, 1'b0);

			if (stb_valid_o) begin
				check_bit("stb_o rise at stb_valid_o", stb_o & ~stb_prev, 1'b1);
				check_bit("request armed at stb_valid_o", req_pending, 1'b1);
				req_pending = 1'b0;
				pulse_count = pulse_count + 1;
			end
			if (stb_req_i && !req_prev) begin
				req_pending = 1'b1;
				req_count   = req_count + 1;
			end

			if (!rdy_o) begin
				have_rise = 1'b0;
			end else if (stb_o && !stb_prev) begin
				if (have_rise) begin
					check_time("stb_o rise spacing", stb_pkg::stb_time_t'(offset + 1), cur_per);
				end
				// any boundary runs on the old or the new period
				if (stb_period_o !== per_old) begin
					check_time("stb_period_o", stb_period_o, per_new);
				end
				cur_per   = stb_period_o;
				offset    = 0;
				have_rise = 1'b1;
			end else begin
				if (!rdy_prev) abort_run("rdy_o rose outside a strobe boundary");
				offset = offset + 1;
				if (stb_pkg::stb_time_t'(offset) >= cur_per) begin
					abort_run("stb_o missed its boundary after a full period");
				end
				check_bit("stb_o", stb_o, expected_strobe(cur_per, offset));
			end

			stb_prev = stb_o;
			rdy_prev = rdy_o;
			req_prev = stb_req_i;
		end
	end

	// watchdog
	initial begin
		wait (budget != 0);
		repeat (budget) @(posedge clk_i);
		abort_run("watchdog: the run took longer than all programmed periods allow");
	end

	// ------------------------------
	// test sequence
	initial begin
		int unsigned half_h [4];
		int unsigned half_l [4];
		int unsigned per [4];
		int unsigned sum;

		arstn_i   = 1'b0;
		stb_req_i = 1'b0;
		void'($urandom(67));
		for (int i = 0; i < 4; i++) begin
			half_h[i] = 4 + $urandom % 16;
			half_l[i] = 4 + $urandom % 16;
		end
		// period change has to be a real change
		if (half_h[1] + half_l[1] == half_h[0] + half_l[0]) half_h[1] = half_h[1] + 3;
		sum = SHORT_H + SHORT_L;
		for (int i = 0; i < 4; i++) begin
			per[i] = half_h[i] + half_l[i];
			sum    = sum + per[i];
		end
		budget = 4 * PHASE_PERIODS * sum + 2 * MAX_P + 1000;

		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		arstn_i = 1'b1;

		// first lock on a steady input
		set_wave(half_h[0], half_l[0], 1'b1);
		wave_on = 1'b1;
		wait_flag(1'b0, 1'b1, 10 * per[0] + 50, "rdy_o never rose for a steady input");
		check_bit("err_o", err_o, 1'b0);
		check_time("stb_period_o", stb_period_o, per[0]);
		repeat (RUN_PERIODS * per[0]) @(negedge clk_i);
		request_strobe(per[0]);

		// period change
		set_wave(half_h[1], half_l[1], 1'b1);
		wait_period(per[1], 4 * (per[0] + per[1]) + 50);
		check_bit("rdy_o", rdy_o, 1'b1);
		repeat (RUN_PERIODS * per[1]) @(negedge clk_i);
		request_strobe(per[1]);

		// period below the limit
		set_wave(SHORT_H, SHORT_L, 1'b0);
		wait_flag(1'b1, 1'b1, 4 * per[1] + 50, "err_o never rose for a short period");
		check_bit("rdy_o", rdy_o, 1'b0);
		repeat (RUN_PERIODS * (SHORT_H + SHORT_L)) @(negedge clk_i);
		check_bit("err_o", err_o, 1'b1);
		check_bit("rdy_o", rdy_o, 1'b0);

		// recovery after the short period
		set_wave(half_h[2], half_l[2], 1'b1);
		wait_flag(1'b1, 1'b0, 10 * per[2] + 50, "err_o stayed high after a good input");
		wait_flag(1'b0, 1'b1, 4 * per[2] + 50, "rdy_o did not return after an error");
		check_time("stb_period_o", stb_period_o, per[2]);
		repeat (RUN_PERIODS * per[2]) @(negedge clk_i);
		request_strobe(per[2]);

		// input stops
		@(posedge clk_i);
		wave_on = 1'b0;
		wait_flag(1'b1, 1'b1, MAX_P + 2 * per[2] + 50, "err_o never rose for a stopped input");
		check_bit("rdy_o", rdy_o, 1'b0);

		// recovery after the silence
		set_wave(half_h[3], half_l[3], 1'b1);
		wave_on = 1'b1;
		wait_flag(1'b1, 1'b0, 10 * per[3] + 50, "err_o stayed high after the input returned");
		wait_flag(1'b0, 1'b1, 4 * per[3] + 50, "rdy_o did not return after a timeout");
		check_time("stb_period_o", stb_period_o, per[3]);
		repeat (RUN_PERIODS * per[3]) @(negedge clk_i);
		request_strobe(per[3]);

		if (req_pending || pulse_count != req_count) begin
			abort_run("a strobe request was not answered with exactly one pulse");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: design/stb_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module stb_gen_top (
	input  wire                clk_i,
	input  wire                arstn_i,
	input  wire                sig_i,
	input  wire                stb_req_i,
	output logic               stb_o,
	output logic               stb_valid_o,
	output logic               rdy_o,
	output logic               err_o,
	output stb_pkg::stb_time_t stb_period_o
);

	stb_pkg::stb_time_t cur_time;
	stb_pkg::stb_time_t edge_time;
	logic               edge_pulse;

	// meter to scheduler link
	period_if per_if ();

	assign err_o = per_if.err;

	time_base i_time_base (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.time_o  (cur_time)
	);

	edge_stamp i_edge_stamp (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.sig_i   (sig_i),
		.time_i  (cur_time),
		.edge_o  (edge_pulse),
		.stamp_o (edge_time)
	);

	period_meter i_period_meter (
		.clk_i   (clk_i),
		.arstn_i (arstn_i),
		.edge_i  (edge_pulse),
		.stamp_i (edge_time),
		.per     (per_if)
	);

	strobe_scheduler i_strobe_scheduler (
		.clk_i        (clk_i),
		.arstn_i      (arstn_i),
		.time_i       (cur_time),
		.stb_req_i    (stb_req_i),
		.per          (per_if),
		.stb_o        (stb_o),
		.rdy_o        (rdy_o),
		.stb_valid_o  (stb_valid_o),
		.stb_period_o (stb_period_o)
	);

endmodule

`default_nettype wire

// File: design/strobe_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "stb_config.svh"

module strobe_scheduler (
	input  wire                     clk_i,
	input  wire                     arstn_i,
	input  wire stb_pkg::stb_time_t time_i,
	input  wire                     stb_req_i,
	period_if.sched                 per,
	output logic                    stb_o,
	output logic                    rdy_o,
	output logic                    stb_valid_o,
	output stb_pkg::stb_time_t      stb_period_o
);

	localparam int W = $bits(stb_pkg::stb_time_t);

	stb_pkg::sched_state_t state_q;
	stb_pkg::stb_time_t    per_q;
	stb_pkg::stb_time_t    bnd_q;
	stb_pkg::stb_time_t    tgt_hi_q;
	stb_pkg::stb_time_t    tgt_lo_q;
	stb_pkg::stb_time_t    d_hi;
	stb_pkg::stb_time_t    d_lo;
	stb_pkg::stb_time_t    next_per;
	logic                  calc_q;
	logic                  tgt_vld_q;
	logic                  cmp_hi_q;
	logic                  cmp_lo_q;
	logic                  rdy_q;
	logic                  req_prev_q;
	logic                  req_arm_q;
	logic                  req_rise;
	logic                  take_first;
	logic                  bnd_evt;
	logic                  abort;

	assign take_first = (state_q == stb_pkg::IDLE) && per.valid;
	assign bnd_evt    = (state_q == stb_pkg::WAIT_HIGH) && cmp_hi_q;
	assign abort      = per.err && (state_q != stb_pkg::IDLE);
	assign per.ready  = (state_q == stb_pkg::IDLE) || bnd_evt;
	assign next_per   = per.valid ? per.period : per_q;
	assign req_rise   = stb_req_i & ~req_prev_q;
	assign rdy_o      = rdy_q & ~per.err;

	// target reached once the difference turns non-negative
	assign d_hi = time_i - tgt_hi_q;
	assign d_lo = time_i - tgt_lo_q;

	// ------------------------------
	// boundary and period, kept STB_LEAD cycles early
	always_ff @(posedge clk_i) begin
		if (take_first) begin
			bnd_q <= per.stamp - stb_pkg::stb_time_t'(`STB_LEAD);
			per_q <= per.period;
		end else if (bnd_evt) begin
			bnd_q <= tgt_hi_q;
			per_q <= next_per;
		end
		// add stage
		if (calc_q) begin
			tgt_hi_q <= bnd_q + per_q;
			tgt_lo_q <= bnd_q + per_q - stb_pkg::stb_time_t'(`STB_ZERO_HOLD);
		end
	end

	// compare stage, blanked until fresh targets are in
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			tgt_vld_q <= 1'b0;
			cmp_hi_q  <= 1'b0;
			cmp_lo_q  <= 1'b0;
		end else begin
			if (abort || bnd_evt || take_first) begin
				tgt_vld_q <= 1'b0;
			end else if (calc_q) begin
				tgt_vld_q <= 1'b1;
			end
			if (bnd_evt || !tgt_vld_q) begin
				cmp_hi_q <= 1'b0;
				cmp_lo_q <= 1'b0;
			end else begin
				cmp_hi_q <= ~d_hi[W-1];
				cmp_lo_q <= ~d_lo[W-1];
			end
		end
	end

	// ------------------------------
	// strobe FSM
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			state_q      <= stb_pkg::IDLE;
			calc_q       <= 1'b0;
			stb_o        <= 1'b0;
			rdy_q        <= 1'b0;
			stb_valid_o  <= 1'b0;
			stb_period_o <= '0;
		end else begin
			calc_q      <= 1'b0;
			stb_valid_o <= 1'b0;
			if (abort) begin
				state_q <= stb_pkg::IDLE;
				stb_o   <= 1'b0;
				rdy_q   <= 1'b0;
			end else begin
				case (state_q)
					stb_pkg::IDLE: begin
						if (per.valid) begin
							calc_q  <= 1'b1;
							state_q <= stb_pkg::PREPARE;
						end
					end
					stb_pkg::PREPARE: state_q <= stb_pkg::WAIT_HIGH;
					stb_pkg::WAIT_LOW: begin
						if (cmp_lo_q) begin
							stb_o   <= 1'b0;
							state_q <= stb_pkg::WAIT_HIGH;
						end
					end
					default: begin
						if (cmp_hi_q) begin
							// strobe boundary
							stb_o        <= 1'b1;
							rdy_q        <= 1'b1;
							stb_valid_o  <= req_arm_q;
							stb_period_o <= next_per;
							calc_q       <= 1'b1;
							state_q      <= stb_pkg::WAIT_LOW;
						end
					end
				endcase
			end
		end
	end

	// request armed by a rising edge, answered at the next boundary
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			req_prev_q <= 1'b0;
			req_arm_q  <= 1'b0;
		end else begin
			req_prev_q <= stb_req_i;
			if (bnd_evt && !abort) begin
				req_arm_q <= req_rise;
			end else if (req_rise) begin
				req_arm_q <= 1'b1;
			end
		end
	end

	assert property (@(posedge clk_i) disable iff (!arstn_i)
		stb_valid_o |-> $rose(stb_o))
		else $error("strobe_scheduler: stb_valid_o outside a strobe rise");

	// an error leaves the ready flag cleared one cycle later
	assert property (@(posedge clk_i) disable iff (!arstn_i)
		per.err |=> !rdy_q)
		else $error("strobe_scheduler: ready while the meter reports an error");

endmodule

`default_nettype wire

// File: design/period_meter.sv
`timescale 1ns/1ps
`default_nettype none

`include "stb_config.svh"

module period_meter (
	input  wire                     clk_i,
	input  wire                     arstn_i,
	input  wire                     edge_i,
	input  wire stb_pkg::stb_time_t stamp_i,
	period_if.meter                 per
);

	localparam int SIL_W = $clog2(`STB_MAX_PERIOD + 1);

	stb_pkg::meter_state_t state_q;
	stb_pkg::stb_time_t    start_q;
	stb_pkg::stb_time_t    diff;
	logic [SIL_W-1:0]      silent_q;
	logic                  measuring;
	logic                  in_range;
	logic                  timeout;
	logic                  good;
	logic                  bad;
	logic                  take;

	assign measuring = (state_q == stb_pkg::MEASURE) || (state_q == stb_pkg::OFFER);
	assign diff      = stamp_i - start_q;
	assign in_range  = (diff >= stb_pkg::stb_time_t'(`STB_MIN_PERIOD)) &&
		(diff <= stb_pkg::stb_time_t'(`STB_MAX_PERIOD));

	// input went quiet for a whole max period
	assign timeout = (state_q != stb_pkg::SKIP_FIRST) && !edge_i &&
		(silent_q == SIL_W'(`STB_MAX_PERIOD - 1));

	assign good = edge_i && measuring && in_range;
	assign bad  = (edge_i && measuring && !in_range) || timeout;
	assign take = per.valid & per.ready;

	// ------------------------------
	// control
	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			state_q   <= stb_pkg::SKIP_FIRST;
			silent_q  <= '0;
			per.valid <= 1'b0;
			per.err   <= 1'b0;
		end else begin
			if (edge_i || state_q == stb_pkg::SKIP_FIRST) begin
				silent_q <= '0;
			end else begin
				silent_q <= silent_q + 1'b1;
			end

			if (bad) begin
				// start over, the next edge is discarded again
				state_q   <= stb_pkg::SKIP_FIRST;
				per.valid <= 1'b0;
				per.err   <= 1'b1;
			end else if (good) begin
				// also overwrites a held item
				state_q   <= stb_pkg::OFFER;
				per.valid <= 1'b1;
				per.err   <= 1'b0;
			end else begin
				case (state_q)
					stb_pkg::SKIP_FIRST: if (edge_i) state_q <= stb_pkg::FIND_START;
					stb_pkg::FIND_START: if (edge_i) state_q <= stb_pkg::MEASURE;
					stb_pkg::OFFER: begin
						if (take) begin
							per.valid <= 1'b0;
							state_q   <= stb_pkg::MEASURE;
						end
					end
					default: state_q <= state_q;
				endcase
			end
		end
	end

	// ------------------------------
	// start stamp and held item
	always_ff @(posedge clk_i) begin
		if (edge_i && state_q != stb_pkg::SKIP_FIRST) begin
			start_q <= stamp_i;
		end
		if (good) begin
			per.period <= diff;
			per.stamp  <= stamp_i;
		end
	end

	// held item only changes when a newer edge arrives
	assert property (@(posedge clk_i) disable iff (!arstn_i)
		(per.valid && !per.ready && !edge_i) |=> ($stable(per.period) && $stable(per.stamp)))
		else $error("period_meter: held item changed without a new edge");

endmodule

`default_nettype wire

// File: design/edge_stamp.sv
`timescale 1ns/1ps
`default_nettype none

`include "stb_config.svh"

module edge_stamp (
	input  wire                     clk_i,
	input  wire                     arstn_i,
	input  wire                     sig_i,
	input  wire stb_pkg::stb_time_t time_i,
	output logic                    edge_o,
	output stb_pkg::stb_time_t      stamp_o
);

	localparam int STAGES = `STB_SYNC_STAGES;

	logic [STAGES-1:0] sync_q;
	logic              prev_q;
	logic              rise;

	// rising edge of the synchronized input
	assign rise = sync_q[STAGES-1] & ~prev_q;

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			sync_q <= '0;
			prev_q <= 1'b0;
			edge_o <= 1'b0;
		end else begin
			sync_q <= {sync_q[STAGES-2:0], sig_i};
			prev_q <= sync_q[STAGES-1];
			edge_o <= rise;
		end
	end

	// stamp goes out together with the pulse
	always_ff @(posedge clk_i) begin
		if (rise) begin
			stamp_o <= time_i;
		end
	end

	// ------------------------------
	// an edge pulse never lasts two cycles
	assert property (@(posedge clk_i) disable iff (!arstn_i)
		edge_o |=> !edge_o)
		else $error("edge_stamp: edge pulse held for two cycles");

endmodule

`default_nettype wire

// File: design/time_base.sv
`timescale 1ns/1ps
`default_nettype none

module time_base (
	input  wire                clk_i,
	input  wire                arstn_i,
	output stb_pkg::stb_time_t time_o
);

	localparam int HALF = $bits(stb_pkg::stb_time_t) / 2;

	logic [HALF-1:0] low_q;
	logic [HALF-1:0] low_dly_q;
	logic [HALF-1:0] high_q;
	logic [HALF-1:0] low_inc;
	logic            low_carry;
	logic            carry_q;

	// low half increment with its carry out
	assign {low_carry, low_inc} = {1'b0, low_q} + 1'b1;

	always_ff @(posedge clk_i or negedge arstn_i) begin
		if (!arstn_i) begin
			low_q     <= '0;
			low_dly_q <= '0;
			carry_q   <= 1'b0;
			high_q    <= '0;
			time_o    <= '0;
		end else begin
			low_q     <= low_inc;
			carry_q   <= low_carry;
			// low half delayed one cycle to line up with the carried high half
			low_dly_q <= low_q;
			high_q    <= high_q + HALF'(carry_q);
			time_o    <= {high_q, low_dly_q};
		end
	end

endmodule

`default_nettype wire

// File: design/period_if.sv
`timescale 1ns/1ps
`default_nettype none

interface period_if;

	// handshake
	logic valid;
	logic ready;

	// payload, held stable from valid until transfer
	stb_pkg::stb_time_t period;
	// timestamp of the edge closing the period
	stb_pkg::stb_time_t stamp;

	// level, high while no good period is available
	logic err;

	modport meter (
		output valid, period, stamp, err,
		input  ready
	);

	modport sched (
		input  valid, period, stamp, err,
		output ready
	);

endinterface

`default_nettype wire

// File: design/stb_pkg.sv
`default_nettype none

`include "stb_config.svh"

package stb_pkg;

	// timestamp or period in clock cycles
	typedef logic [`STB_CNT_WIDTH-1:0] stb_time_t;

	// ------------------------------
	// period meter states
	typedef enum logic [1:0] {
		SKIP_FIRST,
		FIND_START,
		MEASURE,
		OFFER
	} meter_state_t;

	// ------------------------------
	// strobe scheduler states
	typedef enum logic [1:0] {
		IDLE,
		PREPARE,
		WAIT_LOW,
		WAIT_HIGH
	} sched_state_t;

endpackage

`default_nettype wire

// File: design/stb_config.svh
`ifndef STB_CONFIG_SVH
`define STB_CONFIG_SVH

// width of every timestamp and period
`define STB_CNT_WIDTH 32

// flops in the input synchronizer, at least 2
`define STB_SYNC_STAGES 2

// cycles the strobe stays low at the end of a period
`define STB_ZERO_HOLD 1

// accepted input period range, in clock cycles
`define STB_MIN_PERIOD 8
`define STB_MAX_PERIOD 4096

// scheduler compare pipeline depth (compare register plus output register)
`define STB_LEAD 2

`endif
